// ==== uart.f ====
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/tx_shifter.sv
hw/rx_sampler.sv
hw/uart_ctrl.sv
hw/uart_top.sv
verif/uart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=uart_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module uart_tb \
	-f uart.f \
	-Mdir "$BUILD_DIR" -o "$SIM"
status=$?
if [ "$status" -ne 0 ]; then
	echo "run_sim: verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "run_sim: simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	echo "run_sim: simulation reported a failure"
	exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
	echo "run_sim: simulation ended without a result line"
	exit 1
fi

echo "run_sim: simulation clean"
exit 0

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

	import uart_pkg::*;

	localparam int DW           = DEFAULT_DATA_WIDTH;
	localparam int CPB          = DEFAULT_CLOCKS_PER_BIT;
	localparam int FRAME_BITS   = DW + 3;  // start, data, parity, stop
	localparam int FRAME_CYCLES = FRAME_BITS * CPB;
	localparam int CLEAN_FRAMES = 20;
	localparam int TIMED_FRAMES = CLEAN_FRAMES + 3 + 4;  // fault frames plus idle and drain windows
	localparam int TIMEOUT_CYCLES = 3 * TIMED_FRAMES * (FRAME_BITS + 2) * CPB;

	localparam int FAULT_NONE = 0;
	localparam int FAULT_FLIP = 1;  // invert one data bit on the loop
	localparam int FAULT_STOP = 2;  // hold the stop bit low

	typedef struct packed {
		logic          chk;  // compare o_rx_data
		logic          err;  // expected o_rx_error
		logic [DW-1:0] word;
	} exp_entry_t;

	logic          clk;
	logic          reset;
	logic          i_tx_enable;
	logic [DW-1:0] i_tx_data;
	logic          o_tx_busy;
	logic          o_serial;
	logic          serial_loop;  // back into i_serial
	logic [DW-1:0] o_rx_data;
	logic          o_rx_valid;
	logic          o_rx_error;

	logic          loop_on;    // line held idle until reset is done
	logic          flip_line;
	logic          hold_low;
	logic [31:0]   lfsr_state;
	exp_entry_t    expect_q[$];  // frames sent and not yet received
	exp_entry_t    rx_exp;
	int            value_errors;
	int            other_errors;
	int            cycle_count;

	assign serial_loop = !loop_on ? 1'b1 : (hold_low ? 1'b0 : (o_serial ^ flip_line));

	uart_top UUT (
		.clk(clk), .reset(reset),
		.i_tx_enable(i_tx_enable), .i_tx_data(i_tx_data),
		.o_tx_busy(o_tx_busy), .o_serial(o_serial),
		.i_serial(serial_loop),
		.o_rx_data(o_rx_data), .o_rx_valid(o_rx_valid), .o_rx_error(o_rx_error)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		value_errors++;
		$display("Fail %0t %s expected %0h got %0h", $time, name, exp, act);
	endtask

	task automatic report_problem(input string msg);
		other_errors++;
		$display("Error %0t %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("error counts: %0d wrong values, %0d other failures", value_errors, other_errors);
	endtask

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] draw_bits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);  // one step per bit
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			assert (o_serial == 1'b1) else report_mismatch("o_serial", 1, 32'(o_serial));
			assert (o_tx_busy == 1'b0) else report_mismatch("o_tx_busy", 0, 32'(o_tx_busy));
			assert (o_rx_valid == 1'b0) else report_mismatch("o_rx_valid", 0, 32'(o_rx_valid));
			assert (o_rx_error == 1'b0) else report_mismatch("o_rx_error", 0, 32'(o_rx_error));
			tick();
		end
	endtask

	// one frame walked cycle by cycle from its start edge
	task automatic send_frame(input logic [DW-1:0] word, input int mode, input int bad_bit,
		input bit mid_enable);
		logic [FRAME_BITS-1:0] exp_frame;
		exp_entry_t            entry;
		int                    bit_idx;
		exp_frame  = {1'b1, (^word) ^ (DEFAULT_PARITY_ODD != 0), word, 1'b0};  // lsb first
		entry.word = word;
		entry.err  = (mode != FAULT_NONE);
		entry.chk  = (mode != FAULT_FLIP);  // flipped bit corrupts the word
		i_tx_enable = 1'b1;
		i_tx_data   = word;
		expect_q.push_back(entry);
		tick();
		i_tx_enable = 1'b0;
		i_tx_data   = ~word;  // data is captured on the accepting edge
		while (o_serial == 1'b1) begin  // wait for the start bit
			assert (o_tx_busy == 1'b1) else report_mismatch("o_tx_busy", 1, 32'(o_tx_busy));
			tick();
		end
		assert (expect_q.size() == 1)
			else report_problem("previous frame had no valid pulse before this start edge");
		for (int c = 0; c < FRAME_CYCLES; c++) begin
			bit_idx     = c / CPB;
			flip_line   = (mode == FAULT_FLIP) && (bit_idx == bad_bit + 1);
			hold_low    = (mode == FAULT_STOP) && (bit_idx == FRAME_BITS - 1);
			i_tx_enable = mid_enable && (c == FRAME_CYCLES / 2);  // must be ignored
			if (c % CPB == CPB / 2) begin  // bit centre
				assert (o_serial == exp_frame[bit_idx])
					else report_mismatch("o_serial", 32'(exp_frame[bit_idx]), 32'(o_serial));
			end
			assert (o_tx_busy == 1'b1) else report_mismatch("o_tx_busy", 1, 32'(o_tx_busy));
			tick();
		end
		flip_line   = 1'b0;
		hold_low    = 1'b0;
		i_tx_enable = 1'b0;
		// busy ends exactly one frame after the start edge
		assert (o_tx_busy == 1'b0) else report_mismatch("o_tx_busy", 0, 32'(o_tx_busy));
	endtask

	task automatic wait_rx_drain();
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < 2 * FRAME_CYCLES) begin
			tick();
			waited++;
		end
		assert (expect_q.size() == 0)
			else report_problem($sformatf("%0d frames never produced o_rx_valid", expect_q.size()));
	endtask

	// receive side is sampled mid cycle
	always @(negedge clk) begin
		if (!reset && o_rx_valid) begin
			assert (expect_q.size() != 0)
				else report_problem("o_rx_valid pulsed with no frame outstanding");
			if (expect_q.size() != 0) begin
				rx_exp = expect_q.pop_front();
				assert (o_rx_error == rx_exp.err)
					else report_mismatch("o_rx_error", 32'(rx_exp.err), 32'(o_rx_error));
				if (rx_exp.chk) begin
					assert (o_rx_data == rx_exp.word)
						else report_mismatch("o_rx_data", 32'(rx_exp.word), 32'(o_rx_data));
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) (i_tx_enable && !o_tx_busy) |=> o_tx_busy)
		else report_mismatch("o_tx_busy", 1, 0);
	assert property (@(posedge clk) disable iff (reset) o_rx_valid |=> !o_rx_valid)
		else report_mismatch("o_rx_valid", 0, 1);
	assert property (@(posedge clk) disable iff (reset) o_rx_error |-> o_rx_valid)
		else report_problem("o_rx_error high without o_rx_valid");
	assert property (@(posedge clk) disable iff (reset) !o_tx_busy |-> o_serial)
		else report_mismatch("o_serial", 1, 0);  // line idles high

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			report_problem($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
			print_counts();
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		reset        = 1'b1;
		i_tx_enable  = 1'b0;
		i_tx_data    = '0;
		loop_on      = 1'b0;
		flip_line    = 1'b0;
		hold_low     = 1'b0;
		lfsr_state   = 32'ha827_3c0f;
		value_errors = 0;
		other_errors = 0;
		repeat (16) @(posedge clk);
		#1;
		reset   = 1'b0;
		loop_on = 1'b1;
		check_idle(8);  // reset state before any enable
		for (int n = 0; n < CLEAN_FRAMES; n++) begin
			send_frame(DW'(draw_bits(DW)), FAULT_NONE, 0, n == CLEAN_FRAMES - 1);
		end
		wait_rx_drain();
		check_idle(2 * FRAME_CYCLES);  // ignored enable left no frame behind
		send_frame(DW'(draw_bits(DW)), FAULT_FLIP, int'(draw_bits(3)), 1'b0);
		send_frame(DW'(draw_bits(DW)), FAULT_STOP, 0, 1'b0);
		send_frame(DW'(draw_bits(DW)), FAULT_NONE, 0, 1'b0);  // recovery after framing error
		wait_rx_drain();
		check_idle(CPB);
		print_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== hw/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
	parameter int DATA_WIDTH     = uart_pkg::DEFAULT_DATA_WIDTH,
	parameter int CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT,
	parameter int PARITY_EN      = uart_pkg::DEFAULT_PARITY_EN,
	parameter int PARITY_ODD     = uart_pkg::DEFAULT_PARITY_ODD
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_tx_enable,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	output logic                  o_tx_busy,
	output logic                  o_serial,
	input  logic                  i_serial,   // looped back outside
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);

	logic tx_tick, tx_tick_restart, tx_load, tx_shift;
	logic rx_tick, rx_tick_restart, rx_line, rx_start_edge;
	logic rx_sample_data, rx_sample_parity, rx_sample_stop;
	logic rx_parity_bad, rx_stop_bit;

	uart_ctrl #(
		.DATA_WIDTH(DATA_WIDTH), .CLOCKS_PER_BIT(CLOCKS_PER_BIT), .PARITY_EN(PARITY_EN)
	) u_ctrl (
		.clk(clk), .reset(reset),
		.i_tx_enable(i_tx_enable), .o_tx_busy(o_tx_busy),
		.i_tx_tick(tx_tick), .o_tx_tick_restart(tx_tick_restart),
		.o_tx_load(tx_load), .o_tx_shift(tx_shift),
		.i_rx_tick(rx_tick), .i_rx_line(rx_line), .i_rx_start_edge(rx_start_edge),
		.o_rx_tick_restart(rx_tick_restart),
		.o_rx_sample_data(rx_sample_data), .o_rx_sample_parity(rx_sample_parity),
		.o_rx_sample_stop(rx_sample_stop),
		.i_rx_parity_bad(rx_parity_bad), .i_rx_stop_bit(rx_stop_bit),
		.o_rx_valid(o_rx_valid), .o_rx_error(o_rx_error)
	);

	baud_tick_gen #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_tx_baud (
		.clk(clk), .reset(reset), .i_restart(tx_tick_restart),
		.i_half_first(1'b0), .o_tick(tx_tick)  // full periods on transmit
	);

	baud_tick_gen #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_rx_baud (
		.clk(clk), .reset(reset), .i_restart(rx_tick_restart),
		.i_half_first(1'b1), .o_tick(rx_tick)  // centre aligned on receive
	);

	tx_shifter #(
		.DATA_WIDTH(DATA_WIDTH), .PARITY_EN(PARITY_EN), .PARITY_ODD(PARITY_ODD)
	) u_tx_shifter (
		.clk(clk), .reset(reset), .i_load(tx_load), .i_data(i_tx_data),
		.i_shift(tx_shift), .o_serial(o_serial)
	);

	rx_sampler #(
		.DATA_WIDTH(DATA_WIDTH), .PARITY_EN(PARITY_EN), .PARITY_ODD(PARITY_ODD)
	) u_rx_sampler (
		.clk(clk), .reset(reset), .i_serial(i_serial),
		.i_sample_data(rx_sample_data), .i_sample_parity(rx_sample_parity),
		.i_sample_stop(rx_sample_stop),
		.o_line(rx_line), .o_start_edge(rx_start_edge), .o_data(o_rx_data),
		.o_parity_bad(rx_parity_bad), .o_stop_bit(rx_stop_bit)
	);

endmodule

// ==== hw/uart_ctrl.sv ====
`timescale 1ns/1ps

module uart_ctrl #(
	parameter int DATA_WIDTH     = uart_pkg::DEFAULT_DATA_WIDTH,
	parameter int CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT,
	parameter int PARITY_EN      = uart_pkg::DEFAULT_PARITY_EN
) (
	input  logic clk,
	input  logic reset,

	input  logic i_tx_enable,        // one cycle request
	output logic o_tx_busy,
	input  logic i_tx_tick,
	output logic o_tx_tick_restart,
	output logic o_tx_load,          // shifter grabs the word
	output logic o_tx_shift,

	input  logic i_rx_tick,          // bit centres once restarted
	input  logic i_rx_line,          // synchronized level
	input  logic i_rx_start_edge,
	output logic o_rx_tick_restart,
	output logic o_rx_sample_data,
	output logic o_rx_sample_parity,
	output logic o_rx_sample_stop,
	input  logic i_rx_parity_bad,
	input  logic i_rx_stop_bit,
	output logic o_rx_valid,
	output logic o_rx_error
);

	import uart_pkg::*;

	localparam int FRAME_BITS = frame_bits(DATA_WIDTH, PARITY_EN);
	localparam int TX_CNT_W   = $clog2(FRAME_BITS + 1);
	localparam int RX_CNT_W   = $clog2(DATA_WIDTH + 1);

	// synchronizer flush plus half a bit of settled line after reset
	localparam int RX_HOLDOFF = SYNC_STAGES + CLOCKS_PER_BIT / 2;
	localparam int HOLD_W     = $clog2(RX_HOLDOFF + 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_WAIT,  // word loaded, waiting for the first tick
		TX_SEND
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	tx_state_t             tx_state;
	logic [TX_CNT_W-1:0]   tx_cnt;       // shifts done in this frame
	logic                  tx_accept;
	logic                  tx_last;      // stop bit on the line

	rx_state_t             rx_state;
	logic [RX_CNT_W-1:0]   rx_bit_cnt;   // data bits taken
	logic [HOLD_W-1:0]     rx_holdoff;
	logic                  rx_ready;
	logic                  rx_start_ok;
	logic                  rx_valid_q;

	assign tx_accept = (tx_state == TX_IDLE) && i_tx_enable;  // ignored while busy
	assign tx_last   = (tx_cnt == TX_CNT_W'(FRAME_BITS));

	assign o_tx_load         = tx_accept;
	assign o_tx_tick_restart = tx_accept;  // first tick one bit period later
	assign o_tx_busy         = (tx_state != TX_IDLE);
	// first shift puts the start bit out, last tick only ends the stop bit
	assign o_tx_shift = i_tx_tick &&
		((tx_state == TX_WAIT) || ((tx_state == TX_SEND) && !tx_last));

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_state <= TX_IDLE;
			tx_cnt   <= '0;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (tx_accept) begin
						tx_state <= TX_WAIT;
					end
				end
				TX_WAIT: begin
					if (i_tx_tick) begin
						tx_cnt   <= TX_CNT_W'(1);  // start bit going out
						tx_state <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (i_tx_tick) begin
						if (tx_last) begin
							tx_state <= TX_IDLE;  // stop period over, busy drops
						end else begin
							tx_cnt <= tx_cnt + 1'b1;
						end
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign rx_ready    = (rx_holdoff == '0);
	assign rx_start_ok = (rx_state == RX_IDLE) && i_rx_start_edge && rx_ready;

	assign o_rx_tick_restart  = rx_start_ok;  // half period, so ticks hit bit centres
	assign o_rx_sample_data   = i_rx_tick && (rx_state == RX_DATA);
	assign o_rx_sample_parity = i_rx_tick && (rx_state == RX_PARITY);
	assign o_rx_sample_stop   = i_rx_tick && (rx_state == RX_STOP);

	// sampler flags settle the cycle after the stop strobe
	assign o_rx_valid = rx_valid_q;
	assign o_rx_error = rx_valid_q && (i_rx_parity_bad || !i_rx_stop_bit);

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state   <= RX_IDLE;
			rx_bit_cnt <= '0;
			rx_holdoff <= HOLD_W'(RX_HOLDOFF);
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= o_rx_sample_stop;  // one cycle pulse
			if (!rx_ready) begin
				rx_holdoff <= rx_holdoff - 1'b1;
			end
			case (rx_state)
				RX_IDLE: begin
					if (rx_start_ok) begin
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					if (i_rx_tick) begin
						rx_bit_cnt <= '0;
						if (i_rx_line) begin
							rx_state <= RX_IDLE;  // glitch, line back high at centre
						end else begin
							rx_state <= RX_DATA;
						end
					end
				end
				RX_DATA: begin
					if (i_rx_tick) begin
						if (rx_bit_cnt == RX_CNT_W'(DATA_WIDTH - 1)) begin
							rx_state <= (PARITY_EN != 0) ? RX_PARITY : RX_STOP;
						end else begin
							rx_bit_cnt <= rx_bit_cnt + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (i_rx_tick) begin
						rx_state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (i_rx_tick) begin
						rx_state <= RX_IDLE;  // rearm mid stop bit for back to back frames
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/rx_sampler.sv ====
`timescale 1ns/1ps

module rx_sampler #(
	parameter int DATA_WIDTH = uart_pkg::DEFAULT_DATA_WIDTH,
	parameter int PARITY_EN  = uart_pkg::DEFAULT_PARITY_EN,
	parameter int PARITY_ODD = uart_pkg::DEFAULT_PARITY_ODD
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_serial,         // asynchronous line in
	input  logic                  i_sample_data,    // centre of a data bit
	input  logic                  i_sample_parity,  // centre of the parity bit
	input  logic                  i_sample_stop,    // centre of the stop bit
	output logic                  o_line,           // synchronized line level
	output logic                  o_start_edge,     // falling edge seen on o_line
	output logic [DATA_WIDTH-1:0] o_data,           // last complete word
	output logic                  o_parity_bad,
	output logic                  o_stop_bit
);

	import uart_pkg::*;

	logic [SYNC_STAGES-1:0] sync_q;   // [0] takes the raw line
	logic                   line_d;   // o_line one cycle back
	logic [DATA_WIDTH-1:0]  shift_q;  // word being assembled

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;  // preset to idle level
			line_d <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_d <= sync_q[SYNC_STAGES-1];
		end
	end

	assign o_line = sync_q[SYNC_STAGES-1];
	assign o_start_edge = line_d & ~o_line;  // high to low, SYNC_STAGES after the pin

	// right shift, so the first bit ends up in [0]
	always_ff @(posedge clk) begin
		if (i_sample_data) begin
			shift_q <= {o_line, shift_q[DATA_WIDTH-1:1]};
		end
	end

	// output word only changes when a frame completes
	always_ff @(posedge clk) begin
		if (i_sample_stop) begin
			o_data <= shift_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_parity_bad <= 1'b0;
			o_stop_bit   <= 1'b1;
		end else begin
			if (i_sample_data) begin
				o_parity_bad <= 1'b0;  // fresh frame, clear old mismatch
			end
			if ((PARITY_EN != 0) && i_sample_parity) begin
				o_parity_bad <= (o_line != parity_of(shift_q, PARITY_ODD != 0));
			end
			if (i_sample_stop) begin
				o_stop_bit <= o_line;  // low here means a framing error
			end
		end
	end

endmodule

// ==== hw/tx_shifter.sv ====
`timescale 1ns/1ps

module tx_shifter #(
	parameter int DATA_WIDTH = uart_pkg::DEFAULT_DATA_WIDTH,
	parameter int PARITY_EN  = uart_pkg::DEFAULT_PARITY_EN,
	parameter int PARITY_ODD = uart_pkg::DEFAULT_PARITY_ODD
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_load,   // capture a new word
	input  logic [DATA_WIDTH-1:0] i_data,
	input  logic                  i_shift,  // advance one bit
	output logic                  o_serial
);

	import uart_pkg::*;

	localparam int FRAME_BITS = frame_bits(DATA_WIDTH, PARITY_EN);

	logic [FRAME_BITS-1:0] frame;   // {stop, parity, data, start}
	logic [FRAME_BITS:0]   sreg_q;  // frame above the bit now on the line

	always_comb begin
		frame = '1;  // stop bit and any unused slot idle high
		frame[0] = 1'b0;  // start bit
		frame[DATA_WIDTH:1] = i_data;  // lsb goes out first
		if (PARITY_EN != 0) begin
			frame[DATA_WIDTH+1] = parity_of(i_data, PARITY_ODD != 0);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sreg_q <= '1;  // line idles high
		end else if (i_load) begin
			sreg_q <= {frame, 1'b1};  // line stays high until the first shift
		end else if (i_shift) begin
			sreg_q <= {1'b1, sreg_q[FRAME_BITS:1]};  // fill with ones behind the frame
		end
	end

	// after the stop bit the register is all ones again
	assign o_serial = sreg_q[0];

endmodule

// ==== hw/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen #(
	parameter int CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT
) (
	input  logic clk,
	input  logic reset,
	input  logic i_restart,     // reload the bit period
	input  logic i_half_first,  // first period after restart is half length
	output logic o_tick         // one cycle per bit period
);

	localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
	localparam int FULL_LOAD = CLOCKS_PER_BIT - 1;
	localparam int HALF_LOAD = (CLOCKS_PER_BIT / 2 > 0) ? CLOCKS_PER_BIT / 2 - 1 : 0;

	logic [CNT_W-1:0] cnt_q;  // cycles left until the next tick

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q <= CNT_W'(FULL_LOAD);
		end else if (i_restart) begin
			if (i_half_first) begin
				cnt_q <= CNT_W'(HALF_LOAD);  // lands the first tick mid bit
			end else begin
				cnt_q <= CNT_W'(FULL_LOAD);
			end
		end else if (cnt_q == '0) begin
			cnt_q <= CNT_W'(FULL_LOAD);  // wrap, free running
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// tick fires restart + load + 1 cycles after a restart
	assign o_tick = (cnt_q == '0);

endmodule

// ==== hw/uart_pkg.sv ====
package uart_pkg;

	localparam int SYNC_STAGES = 3;  // flops in the rx synchronizer

	localparam int DEFAULT_DATA_WIDTH     = 8;
	localparam int DEFAULT_CLOCKS_PER_BIT = 8;
	localparam int DEFAULT_PARITY_EN      = 1;  // 1 = parity bit present
	localparam int DEFAULT_PARITY_ODD     = 0;  // 0 = even, 1 = odd

	localparam int MAX_DATA_WIDTH = 32;  // widest word parity_of accepts

	// start + data + optional parity + stop
	function automatic int frame_bits(
		input int data_width,
		input int parity_en
	);
		return data_width + parity_en + 2;
	endfunction

	// narrower words are zero extended, which leaves the xor unchanged
	function automatic logic parity_of(
		input logic [MAX_DATA_WIDTH-1:0] word,
		input bit                        odd
	);
		logic p;
		p = ^word;  // even parity bit
		return p ^ odd;  // odd sense flips it
	endfunction

endpackage
